/* exec_stage.f */
+incdir+include
source/exec_pkg.sv
source/exec_alu.sv
source/branch_unit.sv
source/lsu_request.sv
source/trap_control.sv
source/exec_stage.sv
sim/tb_clock.sv
sim/exec_stage_tb.sv

/* include/exec_settings.svh */
// Widths for a 32-bit RV32I execute stage; the byte enable count must equal EXEC_XLEN / 8
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data path width
`define EXEC_XLEN 32

// Instruction tag width, the tag wraps at this width
`define EXEC_TAG_W 3

// Link step for compressed and normal instructions
`define EXEC_STEP_C 2
`define EXEC_STEP_N 4

// One byte enable per byte of a word
`define EXEC_BE_W 4

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the exec_stage testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f exec_stage.f --top-module exec_stage_tb \
    --Mdir "$BUILD_DIR" -o exec_stage_sim

"./$BUILD_DIR/exec_stage_sim" | tee "$LOG_FILE"

if grep -qx "all tests passed" "$LOG_FILE"; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

/* sim/exec_stage_tb.sv */
// Testbench for exec_stage; one table entry per cycle, jump targets only compared when a jump is due
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_stage_tb;

    import exec_pkg::*;

    localparam int CLK_PERIOD = 20;

    typedef struct packed {
        op_e                    op;
        operands_t              opnd;
        logic [`EXEC_TAG_W-1:0] tag_ofs;
        logic                   flush;
        logic                   stall;
        priv_e                  priv;
        exc_flags_t             exc;
        logic                   irq;
        logic [`EXEC_XLEN-1:0]  result;
        logic                   we;
        logic                   chk_mem;
        mem_req_t               mem;
        redirect_t              redir;
        logic                   killed;
    } entry_t;

    logic clk;
    logic reset_n;
    logic flush;
    logic stall;
    op_e op;
    operands_t operands;
    logic [`EXEC_TAG_W-1:0] tag;
    priv_e privilege;
    exc_flags_t exc_flags;
    logic interrupt_pending;
    logic killed;
    mem_req_t mem_req;
    redirect_t redirect;
    logic write_enable;
    op_e operation;
    logic [`EXEC_XLEN-1:0] result;

    entry_t tbl[$];
    logic tbl_ready;
    int errors;
    int checks;

    tb_clock #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(2)) clock0 (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    exec_stage dut0 (
        .clk(clk), .reset_n(reset_n), .flush_i(flush), .stall_i(stall),
        .op_i(op), .operands_i(operands), .tag_i(tag), .privilege_i(privilege),
        .exc_i(exc_flags), .interrupt_pending_i(interrupt_pending), .killed_o(killed),
        .mem_o(mem_req), .redirect_o(redirect), .write_enable_o(write_enable),
        .operation_o(operation), .result_o(result)
    );

    //////////////////////////////////////////////////
    // Table entry builders
    //////////////////////////////////////////////////

    function automatic entry_t blank(op_e o);
        entry_t e;
        e = '0;
        e.op = o;
        e.priv = MACHINE;
        e.redir.exception_code = NE;
        return e;
    endfunction

    function automatic entry_t alu_entry(op_e o, logic [31:0] a, logic [31:0] b, logic [31:0] r);
        entry_t e;
        e = blank(o);
        e.opnd.first = a;
        e.opnd.second = b;
        e.result = r;
        e.we = 1'b1;
        return e;
    endfunction

    // Jumps link pc plus 2 or 4 and other branches leave the plain sum in the result
    function automatic entry_t branch_entry(op_e o, logic [31:0] pc, logic [31:0] a, logic [31:0] b,
            logic [31:0] third, logic comp, logic jump, logic [31:0] target);
        entry_t e;
        logic [`EXEC_XLEN-1:0] step;
        e = alu_entry(o, a, b, a + b);
        step = comp ? `EXEC_STEP_C : `EXEC_STEP_N;
        e.opnd.pc = pc;
        e.opnd.third = third;
        e.opnd.compressed = comp;
        e.redir.jump = jump;
        e.redir.jump_target = target;
        e.we = (o == JAL || o == JALR);
        if (e.we) begin
            e.result = pc + step;
        end
        return e;
    endfunction

    function automatic entry_t memory_entry(op_e o, logic [31:0] a, logic [31:0] b,
            logic [31:0] third, logic [31:0] addr, logic rd, logic [3:0] be, logic [31:0] data);
        entry_t e;
        e = alu_entry(o, a, b, a + b);
        e.opnd.third = third;
        e.we = rd;
        e.chk_mem = 1'b1;
        e.mem.address = addr;
        e.mem.read_enable = rd;
        e.mem.write_enable = be;
        e.mem.write_data = data;
        return e;
    endfunction

    function automatic entry_t trap_entry(op_e o, priv_e p, logic [3:0] exc, logic irq,
            exc_code_e code, logic mret, logic ack, logic we);
        entry_t e;
        e = alu_entry(o, 32'h40, 32'h0, 32'h40);
        e.priv = p;
        e.exc = exc;
        e.irq = irq;
        e.redir.raise_exception = (code != NE);
        e.redir.exception_code = code;
        e.redir.machine_return = mret;
        e.redir.interrupt_ack = ack;
        e.we = we;
        return e;
    endfunction

    // A killed entry keeps its memory request but loses every redirect and its write
    function automatic entry_t cleared(entry_t e);
        e.killed = 1'b1;
        e.we = 1'b0;
        e.redir = '0;
        e.redir.exception_code = NE;
        return e;
    endfunction

    function automatic entry_t as_stale(entry_t e);
        e = cleared(e);
        e.tag_ofs = '1;
        return e;
    endfunction

    function automatic entry_t flushed(entry_t e);
        e = cleared(e);
        e.flush = 1'b1;
        return e;
    endfunction

    function automatic entry_t stalled(entry_t e);
        e.stall = 1'b1;
        return e;
    endfunction

    task automatic build_table();
        tbl.push_back(alu_entry(ADD, 32'd5, 32'd7, 32'd12));
        tbl.push_back(alu_entry(SUB, 32'd5, 32'd7, 32'hFFFF_FFFE));
        tbl.push_back(alu_entry(AND, 32'hF0F0_1234, 32'h0FF0_00FF, 32'h00F0_0034));
        tbl.push_back(alu_entry(OR, 32'hF000_000F, 32'h0000_0F00, 32'hF000_0F0F));
        tbl.push_back(alu_entry(XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 32'hF0F0_0F0F));
        tbl.push_back(alu_entry(SLL, 32'h3, 32'h21, 32'h6));
        tbl.push_back(alu_entry(SRL, 32'h8000_0000, 32'h4, 32'h0800_0000));
        tbl.push_back(alu_entry(SRA, 32'h8000_0000, 32'h4, 32'hF800_0000));
        tbl.push_back(alu_entry(SLT, 32'hFFFF_FFFF, 32'h1, 32'h1));
        tbl.push_back(alu_entry(SLTU, 32'hFFFF_FFFF, 32'h1, 32'h0));
        tbl.push_back(alu_entry(LUI, 32'h1234, 32'hABCD_E000, 32'hABCD_E000));
        tbl.push_back(stalled(alu_entry(ADD, 32'd1, 32'd1, 32'd2)));
        tbl.push_back(stalled(flushed(alu_entry(SUB, 32'd9, 32'd1, 32'd8))));
        // Each taken branch or jump opens a new tag
        tbl.push_back(branch_entry(BEQ, 32'h100, 9, 9, 32'h20, 1'b0, 1'b1, 32'h120));
        tbl.push_back(as_stale(alu_entry(ADD, 32'd3, 32'd4, 32'd7)));
        tbl.push_back(branch_entry(BNE, 32'h200, 9, 9, 32'h40, 1'b0, 1'b0, 32'h0));
        tbl.push_back(branch_entry(BLT, 32'h300, -2, 1, 32'hFFFF_FFF0, 1'b0, 1'b1, 32'h2F0));
        tbl.push_back(branch_entry(BGEU, 32'h400, 1, -1, 32'h8, 1'b0, 1'b0, 32'h0));
        tbl.push_back(branch_entry(BGE, 32'h400, 1, -1, 32'h8, 1'b0, 1'b1, 32'h408));
        tbl.push_back(branch_entry(BLTU, 32'h500, 1, 2, 32'h10, 1'b0, 1'b1, 32'h510));
        tbl.push_back(branch_entry(JAL, 32'h600, 32'h600, 32'h80, 0, 1'b1, 1'b1, 32'h680));
        tbl.push_back(branch_entry(JALR, 32'h700, 32'h1001, 32'h4, 0, 1'b0, 1'b1, 32'h1004));
        tbl.push_back(as_stale(alu_entry(ADD, 32'd3, 32'd4, 32'd7)));
        tbl.push_back(flushed(alu_entry(XOR, 32'd1, 32'd3, 32'd2)));
        tbl.push_back(as_stale(branch_entry(JAL, 32'h800, 32'h800, 32'h10, 0, 1'b0, 1'b1, 0)));
        // Stores at every lane, then loads
        tbl.push_back(memory_entry(SB, 32'h1000, 0, 32'hAB, 32'h1000, 1'b0, 4'b0001, 32'hABAB_ABAB));
        tbl.push_back(memory_entry(SB, 32'h1000, 1, 32'hAB, 32'h1000, 1'b0, 4'b0010, 32'hABAB_ABAB));
        tbl.push_back(memory_entry(SB, 32'h1000, 2, 32'hAB, 32'h1000, 1'b0, 4'b0100, 32'hABAB_ABAB));
        tbl.push_back(memory_entry(SB, 32'h1000, 3, 32'hAB, 32'h1000, 1'b0, 4'b1000, 32'hABAB_ABAB));
        tbl.push_back(memory_entry(SH, 32'h2000, 0, 32'h1234_5678, 32'h2000, 1'b0, 4'b0011,
                                   32'h5678_5678));
        tbl.push_back(memory_entry(SH, 32'h2000, 2, 32'h1234_5678, 32'h2000, 1'b0, 4'b1100,
                                   32'h5678_5678));
        tbl.push_back(memory_entry(SW, 32'h3000, 4, 32'hDEAD_BEEF, 32'h3004, 1'b0, 4'b1111,
                                   32'hDEAD_BEEF));
        tbl.push_back(memory_entry(LW, 32'h4000, 32'hB, 0, 32'h4008, 1'b1, 4'b0000, 0));
        tbl.push_back(memory_entry(LB, 32'h4000, 32'h1, 0, 32'h4000, 1'b1, 4'b0000, 0));
        tbl.push_back(memory_entry(LHU, 32'h4000, 32'h6, 0, 32'h4004, 1'b1, 4'b0000, 0));
        // Flag order is illegal, misaligned fetch, fetch fault, load fault
        tbl.push_back(trap_entry(ADD, MACHINE, 4'b1111, 1'b0, INSTRUCTION_ACCESS_FAULT, 0, 0, 0));
        tbl.push_back(trap_entry(ADD, MACHINE, 4'b1100, 1'b0, ILLEGAL_INSTRUCTION, 0, 0, 0));
        tbl.push_back(trap_entry(ECALL, USER, 4'b0100, 1'b0, INSTRUCTION_ADDRESS_MISALIGNED, 0, 0, 0));
        tbl.push_back(trap_entry(ECALL, USER, 4'b0000, 1'b0, ECALL_FROM_UMODE, 0, 0, 0));
        tbl.push_back(trap_entry(ECALL, MACHINE, 4'b0000, 1'b0, ECALL_FROM_MMODE, 0, 0, 0));
        tbl.push_back(trap_entry(EBREAK, MACHINE, 4'b0001, 1'b0, BREAKPOINT, 0, 0, 0));
        tbl.push_back(trap_entry(ADD, MACHINE, 4'b0001, 1'b0, NE, 0, 0, 1));
        tbl.push_back(trap_entry(LW, MACHINE, 4'b0001, 1'b0, LOAD_ACCESS_FAULT, 0, 0, 0));
        tbl.push_back(flushed(trap_entry(ECALL, USER, 4'b0000, 1'b0, ECALL_FROM_UMODE, 0, 0, 0)));
        tbl.push_back(trap_entry(MRET, MACHINE, 4'b0000, 1'b1, NE, 1, 0, 1));
        tbl.push_back(as_stale(trap_entry(ADD, MACHINE, 4'b0000, 1'b1, NE, 0, 1, 1)));
        tbl.push_back(trap_entry(NOP, MACHINE, 4'b0000, 1'b1, NE, 0, 0, 0));
        tbl.push_back(trap_entry(ADD, MACHINE, 4'b0000, 1'b1, NE, 0, 1, 1));
        tbl.push_back(as_stale(trap_entry(ADD, MACHINE, 4'b0000, 1'b1, NE, 0, 1, 1)));
        tbl.push_back(alu_entry(ADD, 32'd2, 32'd2, 32'd4));
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_writeback(string label, logic [`EXEC_XLEN-1:0] exp_res, op_e exp_op,
                                   logic exp_we);
        checks++;
        if (result !== exp_res || operation !== exp_op || write_enable !== exp_we) begin
            errors++;
            $display("Mismatch at %0t: %s writeback %h %s we %b, expected %h %s we %b", $time,
                     label, result, operation.name(), write_enable, exp_res, exp_op.name(), exp_we);
        end
    endtask

    task automatic compare_mem_req(string label, mem_req_t got, mem_req_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s mem %h rd %b be %b data %h, expected %h %b %b %h",
                     $time, label, got.address, got.read_enable, got.write_enable,
                     got.write_data, exp.address, exp.read_enable, exp.write_enable,
                     exp.write_data);
        end
    endtask

    task automatic verify_redirect(string label, redirect_t got, redirect_t exp,
                                   logic got_killed, logic exp_killed);
        redirect_t seen;
        seen = got;
        if (!exp.jump) begin
            seen.jump_target = exp.jump_target;
        end
        checks++;
        if (seen !== exp || got_killed !== exp_killed) begin
            errors++;
            $display("Mismatch at %0t: %s redirect %h killed %b, expected %h killed %b",
                     $time, label, got, got_killed, exp, exp_killed);
        end
    endtask

    //////////////////////////////////////////////////
    // Apply loop and watchdog
    //////////////////////////////////////////////////

    initial begin
        entry_t e;
        string label;
        logic [`EXEC_TAG_W-1:0] exp_tag;
        logic [`EXEC_XLEN-1:0] exp_result;
        op_e exp_op;
        logic exp_we;
        flush = 1'b0;
        stall = 1'b0;
        op = NOP;
        operands = '0;
        tag = '0;
        privilege = MACHINE;
        exc_flags = '0;
        interrupt_pending = 1'b0;
        errors = 0;
        checks = 0;
        exp_tag = '0;
        exp_result = '0;
        exp_op = NOP;
        exp_we = 1'b0;
        tbl_ready = 1'b0;
        build_table();
        tbl_ready = 1'b1;
        // Reset is released on a falling edge, before any rising edge can load the outputs
        wait (reset_n === 1'b1);
        label = "reset";
        for (int i = 0; i < tbl.size(); i++) begin
            e = tbl[i];
            // Registered outputs of the previous entry
            check_writeback(label, exp_result, exp_op, exp_we);
            op = e.op;
            operands = e.opnd;
            tag = exp_tag + e.tag_ofs;
            flush = e.flush;
            stall = e.stall;
            privilege = e.priv;
            exc_flags = e.exc;
            interrupt_pending = e.irq;
            label = $sformatf("entry %0d %s", i, e.op.name());
            #(CLK_PERIOD / 4);
            verify_redirect(label, redirect, e.redir, killed, e.killed);
            if (e.chk_mem) begin
                compare_mem_req(label, mem_req, e.mem);
            end
            if (!e.stall) begin
                exp_result = e.result;
                exp_op = e.op;
                exp_we = e.we;
            end
            if (e.redir.jump | e.redir.raise_exception | e.redir.machine_return |
                e.redir.interrupt_ack) begin
                exp_tag = exp_tag + 1'b1;
            end
            @(negedge clk);
        end
        check_writeback(label, exp_result, exp_op, exp_we);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        wait (tbl_ready === 1'b1);
        #((tbl.size() + 10) * CLK_PERIOD);
        $display("Timeout: the stimulus table did not finish within its cycle budget");
        $display("tests failed");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
// Simulation-only clock and reset source; reset is released on a falling edge after RESET_CYCLES
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_n_o = 1'b1;
    end

endmodule

/* source/branch_unit.sv */
// Branch decision from ALU flags; targets are not checked for alignment here
`timescale 1ns/1ps
`include "exec_settings.svh"

module branch_unit (
    input  exec_pkg::op_e           op_i,
    input  logic [`EXEC_XLEN-1:0]   sum_i,
    input  logic [`EXEC_XLEN-1:0]   link_sum_i,
    input  exec_pkg::alu_flags_t    flags_i,
    input  logic                    killed_i,
    output logic                    jump_o,
    output logic [`EXEC_XLEN-1:0]   jump_target_o
);

    import exec_pkg::*;

    logic taken;

    always_comb begin
        case (op_i)
            BEQ:       taken = flags_i.equal;
            BNE:       taken = ~flags_i.equal;
            BLT:       taken = flags_i.less_than;
            BLTU:      taken = flags_i.less_than_unsigned;
            BGE:       taken = flags_i.greater_equal;
            BGEU:      taken = flags_i.greater_equal_unsigned;
            JAL, JALR: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    // jalr drops bit 0 of rs1 plus offset, branches use pc plus third
    always_comb begin
        case (op_i)
            JALR:    jump_target_o = {sum_i[`EXEC_XLEN-1:1], 1'b0};
            JAL:     jump_target_o = sum_i;
            default: jump_target_o = link_sum_i;
        endcase
    end

    assign jump_o = taken & ~killed_i;

endmodule

/* source/exec_alu.sv */
// Combinational RV32I ALU; shift amount is second[4:0], no overflow or carry is reported
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_alu (
    input  exec_pkg::op_e           op_i,
    input  exec_pkg::operands_t     operands_i,
    output logic [`EXEC_XLEN-1:0]   sum_result_o,
    output logic [`EXEC_XLEN-1:0]   link_result_o,
    output logic [`EXEC_XLEN-1:0]   alu_result_o,
    output exec_pkg::alu_flags_t    flags_o
);

    import exec_pkg::*;

    localparam logic [`EXEC_XLEN-1:0] STEP_C = `EXEC_STEP_C;
    localparam logic [`EXEC_XLEN-1:0] STEP_N = `EXEC_STEP_N;

    logic [`EXEC_XLEN-1:0] add2_a;
    logic [`EXEC_XLEN-1:0] add2_b;
    logic [4:0]            shamt;

    assign shamt = operands_i.second[4:0];

    //////////////////////////////////////////////////
    // Adders
    //////////////////////////////////////////////////

    // Main adder serves add, loads, stores and jump targets
    assign sum_result_o = operands_i.first + operands_i.second;

    // Second adder: difference for sub, link for jumps, branch target otherwise
    always_comb begin
        add2_a = operands_i.pc;
        add2_b = operands_i.third;
        case (op_i)
            SUB: begin
                add2_a = operands_i.first;
                add2_b = ~operands_i.second + 1'b1;
            end
            JAL, JALR: begin
                add2_b = operands_i.compressed ? STEP_C : STEP_N;
            end
            default: begin
                add2_b = operands_i.third;
            end
        endcase
    end

    assign link_result_o = add2_a + add2_b;

    //////////////////////////////////////////////////
    // Comparisons
    //////////////////////////////////////////////////

    always_comb begin
        flags_o.equal                  = operands_i.first == operands_i.second;
        flags_o.less_than              = $signed(operands_i.first) < $signed(operands_i.second);
        flags_o.less_than_unsigned     = operands_i.first < operands_i.second;
        flags_o.greater_equal          = $signed(operands_i.first) >= $signed(operands_i.second);
        flags_o.greater_equal_unsigned = operands_i.first >= operands_i.second;
    end

    //////////////////////////////////////////////////
    // Result select
    //////////////////////////////////////////////////

    always_comb begin
        case (op_i)
            AND:     alu_result_o = operands_i.first & operands_i.second;
            OR:      alu_result_o = operands_i.first | operands_i.second;
            XOR:     alu_result_o = operands_i.first ^ operands_i.second;
            SLL:     alu_result_o = operands_i.first << shamt;
            SRL:     alu_result_o = operands_i.first >> shamt;
            SRA:     alu_result_o = $signed(operands_i.first) >>> shamt;
            SLT:     alu_result_o = {{(`EXEC_XLEN-1){1'b0}}, flags_o.less_than};
            SLTU:    alu_result_o = {{(`EXEC_XLEN-1){1'b0}}, flags_o.less_than_unsigned};
            // Upper immediate arrives already shifted in second
            LUI:     alu_result_o = operands_i.second;
            default: alu_result_o = sum_result_o;
        endcase
    end

endmodule

/* source/exec_pkg.sv */
// Types of the execute stage; exception codes follow the RISC-V mcause numbering, NE is 4'hF
`include "exec_settings.svh"

package exec_pkg;

    // Decoded operation from the issue stage
    typedef enum logic [4:0] {
        NOP, LUI, ADD, SUB, SLT, SLTU, XOR, OR, AND,
        SLL, SRL, SRA,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        JAL, JALR, ECALL, EBREAK, MRET
    } op_e;

    // Trap cause, NE means no exception
    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        INSTRUCTION_ACCESS_FAULT       = 4'd1,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        LOAD_ACCESS_FAULT              = 4'd5,
        ECALL_FROM_UMODE               = 4'd8,
        ECALL_FROM_MMODE               = 4'd11,
        NE                             = 4'd15
    } exc_code_e;

    typedef enum logic [1:0] {
        USER    = 2'b00,
        MACHINE = 2'b11
    } priv_e;

    // Issued instruction data
    typedef struct packed {
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] first;
        logic [`EXEC_XLEN-1:0] second;
        logic [`EXEC_XLEN-1:0] third;
        logic                  compressed;
    } operands_t;

    // Faults flagged by fetch and decode
    typedef struct packed {
        logic illegal;
        logic misaligned_fetch;
        logic inst_access_fault;
        logic load_access_fault;
    } exc_flags_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] address;
        logic                  read_enable;
        logic [`EXEC_BE_W-1:0] write_enable;
        logic [`EXEC_XLEN-1:0] write_data;
    } mem_req_t;

    // Control flow change towards fetch
    typedef struct packed {
        logic                  jump;
        logic [`EXEC_XLEN-1:0] jump_target;
        logic                  raise_exception;
        exc_code_e             exception_code;
        logic                  machine_return;
        logic                  interrupt_ack;
    } redirect_t;

    typedef struct packed {
        logic equal;
        logic less_than;
        logic less_than_unsigned;
        logic greater_equal;
        logic greater_equal_unsigned;
    } alu_flags_t;

endpackage

/* source/exec_stage.sv */
// RV32I execute stage without M extension or CSR access; no handshake, stall_i holds the result
`timescale 1ns/1ps
`include "exec_settings.svh"

module exec_stage (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     flush_i,
    input  logic                     stall_i,
    input  exec_pkg::op_e            op_i,
    input  exec_pkg::operands_t      operands_i,
    input  logic [`EXEC_TAG_W-1:0]   tag_i,
    input  exec_pkg::priv_e          privilege_i,
    input  exec_pkg::exc_flags_t     exc_i,
    input  logic                     interrupt_pending_i,
    output logic                     killed_o,
    output exec_pkg::mem_req_t       mem_o,
    output exec_pkg::redirect_t      redirect_o,
    output logic                     write_enable_o,
    output exec_pkg::op_e            operation_o,
    output logic [`EXEC_XLEN-1:0]    result_o
);

    import exec_pkg::*;

    logic [`EXEC_TAG_W-1:0] curr_tag;
    logic                   killed;
    logic                   trap_kill;
    logic                   branch_kill;
    logic [`EXEC_XLEN-1:0]  sum_result;
    logic [`EXEC_XLEN-1:0]  link_result;
    logic [`EXEC_XLEN-1:0]  alu_result;
    alu_flags_t             flags;
    logic                   mem_access;
    logic                   jump;
    logic [`EXEC_XLEN-1:0]  jump_target;
    logic                   raise_exception;
    exc_code_e              exception_code;
    logic                   machine_return;
    logic                   interrupt_ack;
    logic [`EXEC_XLEN-1:0]  result;
    logic                   write_enable;

    //////////////////////////////////////////////////
    // Tag and kill
    //////////////////////////////////////////////////

    assign killed   = (tag_i != curr_tag) | flush_i;
    assign killed_o = killed;

    // Traps stay quiet while reset is held
    assign trap_kill = killed | ~reset_n;

    // A raised exception overrides the jump of the same instruction
    assign branch_kill = killed | raise_exception;

    // Any redirect opens a new tag, stale instructions are then killed
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            curr_tag <= '0;
        end else if (jump | raise_exception | machine_return | interrupt_ack) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Datapath units
    //////////////////////////////////////////////////

    exec_alu alu0 (
        .op_i          (op_i),
        .operands_i    (operands_i),
        .sum_result_o  (sum_result),
        .link_result_o (link_result),
        .alu_result_o  (alu_result),
        .flags_o       (flags)
    );

    branch_unit branch0 (
        .op_i          (op_i),
        .sum_i         (sum_result),
        .link_sum_i    (link_result),
        .flags_i       (flags),
        .killed_i      (branch_kill),
        .jump_o        (jump),
        .jump_target_o (jump_target)
    );

    lsu_request lsu0 (
        .op_i         (op_i),
        .sum_i        (sum_result),
        .store_data_i (operands_i.third),
        .mem_o        (mem_o),
        .mem_access_o (mem_access)
    );

    trap_control trap0 (
        .op_i                (op_i),
        .privilege_i         (privilege_i),
        .exc_i               (exc_i),
        .mem_access_i        (mem_access),
        .interrupt_pending_i (interrupt_pending_i),
        .killed_i            (trap_kill),
        .raise_exception_o   (raise_exception),
        .exception_code_o    (exception_code),
        .machine_return_o    (machine_return),
        .interrupt_ack_o     (interrupt_ack)
    );

    assign redirect_o.jump            = jump;
    assign redirect_o.jump_target     = jump_target;
    assign redirect_o.raise_exception = raise_exception;
    assign redirect_o.exception_code  = exception_code;
    assign redirect_o.machine_return  = machine_return;
    assign redirect_o.interrupt_ack   = interrupt_ack;

    //////////////////////////////////////////////////
    // Result and writeback
    //////////////////////////////////////////////////

    // Link for jumps and the difference for sub come from the second adder
    assign result = (op_i inside {JAL, JALR, SUB}) ? link_result : alu_result;

    always_comb begin
        case (op_i)
            NOP, SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU: write_enable = 1'b0;
            default: write_enable = ~(killed | raise_exception);
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_enable_o <= 1'b0;
            operation_o    <= NOP;
            result_o       <= '0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
            operation_o    <= op_i;
            result_o       <= result;
        end
    end

    // Fetch never gets a jump and a trap in the same cycle
    assert property (@(posedge clk) disable iff (!reset_n)
                     !(redirect_o.jump && redirect_o.raise_exception))
    else $error("exec_stage: jump and exception redirect together");

endmodule

/* source/lsu_request.sv */
// Word-aligned load/store request; the memory side picks bytes of a load itself
`timescale 1ns/1ps
`include "exec_settings.svh"

module lsu_request (
    input  exec_pkg::op_e           op_i,
    input  logic [`EXEC_XLEN-1:0]   sum_i,
    input  logic [`EXEC_XLEN-1:0]   store_data_i,
    output exec_pkg::mem_req_t      mem_o,
    output logic                    mem_access_o
);

    import exec_pkg::*;

    assign mem_o.address     = {sum_i[`EXEC_XLEN-1:2], 2'b00};
    assign mem_o.read_enable = op_i inside {LB, LBU, LH, LHU, LW};

    // Narrow stores replicate the data over the whole word
    always_comb begin
        case (op_i)
            SB:      mem_o.write_data = {`EXEC_BE_W{store_data_i[7:0]}};
            SH:      mem_o.write_data = {(`EXEC_BE_W/2){store_data_i[15:0]}};
            default: mem_o.write_data = store_data_i;
        endcase
    end

    // Lane select from the low address bits
    always_comb begin
        case (op_i)
            SB:      mem_o.write_enable = {{(`EXEC_BE_W-1){1'b0}}, 1'b1} << sum_i[1:0];
            SH:      mem_o.write_enable = sum_i[1] ? 4'b1100 : 4'b0011;
            SW:      mem_o.write_enable = '1;
            default: mem_o.write_enable = '0;
        endcase
    end

    assign mem_access_o = mem_o.read_enable | (|mem_o.write_enable);

    // Byte lanes are one byte, an aligned half or the full word
    always_comb begin
        assert ($onehot0(mem_o.write_enable) ||
                mem_o.write_enable inside {4'b0011, 4'b1100, 4'b1111})
        else $error("lsu_request: illegal byte enables %b", mem_o.write_enable);
    end

endmodule

/* source/trap_control.sv */
// Fixed trap priority, one strobe at a time; interrupts are taken on any valid op
`timescale 1ns/1ps

module trap_control (
    input  exec_pkg::op_e           op_i,
    input  exec_pkg::priv_e         privilege_i,
    input  exec_pkg::exc_flags_t    exc_i,
    input  logic                    mem_access_i,
    input  logic                    interrupt_pending_i,
    input  logic                    killed_i,
    output logic                    raise_exception_o,
    output exec_pkg::exc_code_e     exception_code_o,
    output logic                    machine_return_o,
    output logic                    interrupt_ack_o
);

    import exec_pkg::*;

    always_comb begin
        raise_exception_o = 1'b0;
        machine_return_o  = 1'b0;
        interrupt_ack_o   = 1'b0;
        exception_code_o  = NE;

        if (!killed_i) begin
            // Highest priority first
            if (exc_i.inst_access_fault) begin
                raise_exception_o = 1'b1;
                exception_code_o  = INSTRUCTION_ACCESS_FAULT;
            end else if (exc_i.illegal) begin
                raise_exception_o = 1'b1;
                exception_code_o  = ILLEGAL_INSTRUCTION;
            end else if (exc_i.misaligned_fetch) begin
                raise_exception_o = 1'b1;
                exception_code_o  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op_i == ECALL) begin
                raise_exception_o = 1'b1;
                exception_code_o  = (privilege_i == USER) ? ECALL_FROM_UMODE
                                                          : ECALL_FROM_MMODE;
            end else if (op_i == EBREAK) begin
                raise_exception_o = 1'b1;
                exception_code_o  = BREAKPOINT;
            end else if (exc_i.load_access_fault && mem_access_i) begin
                // Fault only counts for an actual memory access
                raise_exception_o = 1'b1;
                exception_code_o  = LOAD_ACCESS_FAULT;
            end else if (op_i == MRET) begin
                machine_return_o = 1'b1;
            end else if (interrupt_pending_i && op_i != NOP) begin
                interrupt_ack_o = 1'b1;
            end
        end
    end

    // Fetch sees a single kind of redirect per cycle
    always_comb begin
        assert ($onehot0({raise_exception_o, machine_return_o, interrupt_ack_o}))
        else $error("trap_control: more than one trap strobe active");
    end

endmodule
